/* Makefile */
# Verilator build and run for the AES control testbench

VERILATOR ?= verilator
TOP       ?= tb_aes_ctrl
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* aes_cmd_latch.sv */
// AES command latch with input handshake, command register and illegal command check
module aes_cmd_latch import aes_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Command handshake
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  aes_cmd_u cmd_i,

  // Release from the FSM once the result is taken
  input  logic     cmd_done_i,

  // Decoded command
  output logic     cmd_valid_o,
  output logic     cmd_illegal_o,
  output logic     is_clear_o,
  output ciph_op_e op_o,
  output key_len_e key_len_o,
  output logic     dec_key_gen_o,
  output logic     key_clear_o,
  output logic     data_out_clear_o
);

  aes_cmd_u cmd_q;
  logic     cmd_valid_q;
  logic     cmd_illegal_q;
  logic     accept;
  logic     illegal_d;
  logic     is_start;

  // Busy while a command is held
  assign in_ready_o = ~cmd_valid_q;
  assign accept     = in_valid_i & in_ready_o;

  ////////////////////////////////////////
  // Illegal command detection
  ////////////////////////////////////////

  always_comb begin
    case (cmd_i.start.kind)
      // Key length 2'b11 is not a valid key size
      CMD_KIND_START: illegal_d = !(cmd_i.start.key_len inside {AES_128, AES_192, AES_256});
      // A clear must name at least one target
      CMD_KIND_CLEAR: illegal_d = ~(cmd_i.clear.key_clear | cmd_i.clear.data_out_clear);
      default:        illegal_d = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Command register
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_q   <= 1'b0;
      cmd_illegal_q <= 1'b0;
      cmd_q         <= '0;
    end else if (accept) begin
      cmd_valid_q   <= 1'b1;
      cmd_illegal_q <= illegal_d;
      cmd_q         <= cmd_i;
    end else if (cmd_done_i) begin
      // Illegal commands are never released, the FSM stays in ERROR
      cmd_valid_q   <= 1'b0;
    end
  end

  assign cmd_valid_o   = cmd_valid_q;
  assign cmd_illegal_o = cmd_illegal_q;

  ////////////////////////////////////////
  // Decode through the selected view
  ////////////////////////////////////////

  assign is_start   = cmd_q.start.kind == CMD_KIND_START;
  assign is_clear_o = cmd_q.clear.kind == CMD_KIND_CLEAR;

  // Start fields, neutral for a clear
  assign op_o          = is_start ? cmd_q.start.op : CIPH_FWD;
  assign key_len_o     = is_start ? cmd_q.start.key_len : AES_128;
  assign dec_key_gen_o = is_start & cmd_q.start.dec_key_gen;

  // Clear fields, low for a start
  assign key_clear_o      = is_clear_o & cmd_q.clear.key_clear;
  assign data_out_clear_o = is_clear_o & cmd_q.clear.data_out_clear;

endmodule

/* aes_ctrl_patterns.txt */
// cmd sb_lat ke_lat hold fault | exp: rnd ke_acks sb_acks key_dec_we alert
// Latency 0 is random, ff skips the check
40 01 02 00 00  0a 0a 0a 00 00
48 00 00 00 00  0c 0c 0c 00 00
50 02 01 00 00  0e 0d 0e 00 00
60 01 01 00 00  0a 0a 0a 00 00
68 00 01 05 00  0c 0c 0c 00 00
70 01 00 00 00  0e 0d 0e 00 00
64 01 01 00 00  ff 0a 00 01 00
74 01 02 03 00  ff 0d 00 01 00
a0 01 01 00 00  ff 00 00 01 00
90 00 00 00 00  ff 00 00 00 00
b0 00 00 02 00  ff 00 00 03 00
c0 01 01 00 00  ff ff ff ff 01
58 01 01 00 00  ff ff ff ff 01
40 01 01 00 01  ff ff ff ff 01
40 03 03 00 00  0a 0a 0a 00 00

/* aes_ctrl_pkg.sv */
// AES control package with the command word union, selector encodings and round constants
package aes_ctrl_pkg;

  ////////////////////////////////////////
  // Widths and round counts
  ////////////////////////////////////////

  localparam int unsigned RND_CTR_W = 4;
  localparam int unsigned CMD_W     = 8;

  // Number of rounds per key length
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_128 = 10;
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_192 = 12;
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_256 = 14;

  // Command kind field, any other value is illegal
  localparam logic [1:0] CMD_KIND_START = 2'b01;
  localparam logic [1:0] CMD_KIND_CLEAR = 2'b10;

  ////////////////////////////////////////
  // Command fields
  ////////////////////////////////////////

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Encoding 2'b11 is illegal
  typedef enum logic [1:0] {
    AES_128 = 2'b00,
    AES_192 = 2'b01,
    AES_256 = 2'b10
  } key_len_e;

  // Start view of the command word
  typedef struct packed {
    logic [1:0]       kind;
    ciph_op_e         op;
    key_len_e         key_len;
    logic             dec_key_gen;
    logic [CMD_W-7:0] rsvd;
  } cmd_start_t;

  // Clear view of the command word
  typedef struct packed {
    logic [1:0]       kind;
    logic             key_clear;
    logic             data_out_clear;
    logic [CMD_W-5:0] rsvd;
  } cmd_clear_t;

  // One command word, decoded by the view its kind selects
  typedef union packed {
    cmd_start_t start;
    cmd_clear_t clear;
  } aes_cmd_u;

  ////////////////////////////////////////
  // FSM phase and data path selectors
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    CTRL_IDLE     = 3'd0,
    CTRL_INIT     = 3'd1,
    CTRL_ROUND    = 3'd2,
    CTRL_FINISH   = 3'd3,
    CTRL_CLEAR_S  = 3'd4,
    CTRL_CLEAR_KD = 3'd5,
    CTRL_ERROR    = 3'd6
  } ctrl_phase_e;

  typedef enum logic [1:0] {
    STATE_ROUND = 2'd0,
    STATE_INIT  = 2'd1,
    STATE_CLEAR = 2'd2
  } state_sel_e;

  typedef enum logic [1:0] {
    ADD_RK_INIT  = 2'd0,
    ADD_RK_ROUND = 2'd1,
    ADD_RK_FINAL = 2'd2
  } add_rk_sel_e;

  typedef enum logic [1:0] {
    KEY_FULL_ENC_INIT = 2'd0,
    KEY_FULL_DEC_INIT = 2'd1,
    KEY_FULL_ROUND    = 2'd2,
    KEY_FULL_CLEAR    = 2'd3
  } key_full_sel_e;

  typedef enum logic {
    KEY_DEC_EXPAND = 1'b0,
    KEY_DEC_CLEAR  = 1'b1
  } key_dec_sel_e;

  typedef enum logic [1:0] {
    KEY_WORDS_ZERO = 2'd0,
    KEY_WORDS_0123 = 2'd1,
    KEY_WORDS_2345 = 2'd2,
    KEY_WORDS_4567 = 2'd3
  } key_words_sel_e;

  typedef enum logic {
    ROUND_KEY_DIRECT = 1'b0,
    ROUND_KEY_MIXED  = 1'b1
  } round_key_sel_e;

endpackage

/* aes_ctrl_top.sv */
// AES cipher control top joining command latch, round FSM and selector encoder
module aes_ctrl_top import aes_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Command handshake
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  aes_cmd_u             cmd_i,

  // Result handshake
  output logic                 out_valid_o,
  input  logic                 out_ready_i,

  // Cipher data path
  output state_sel_e           state_sel_o,
  output logic                 state_we_o,
  output add_rk_sel_e          add_rk_sel_o,
  output logic                 sub_bytes_en_o,
  input  logic                 sub_bytes_out_req_i,
  output logic                 sub_bytes_out_ack_o,

  // Key expand data path
  output key_full_sel_e        key_full_sel_o,
  output logic                 key_full_we_o,
  output key_dec_sel_e         key_dec_sel_o,
  output logic                 key_dec_we_o,
  output logic                 key_expand_en_o,
  input  logic                 key_expand_out_req_i,
  output logic                 key_expand_out_ack_o,
  output logic                 key_expand_clear_o,
  output logic [RND_CTR_W-1:0] rnd_ctr_o,
  output key_words_sel_e       key_words_sel_o,
  output round_key_sel_e       round_key_sel_o,

  // Faults
  input  logic                 sel_err_i,
  input  logic                 ctr_err_i,
  input  logic                 fatal_i,
  output logic                 alert_o
);

  // Latched command towards FSM and encoder
  logic        cmd_valid;
  logic        cmd_illegal;
  logic        cmd_done;
  logic        is_clear;
  ciph_op_e    op;
  key_len_e    key_len;
  logic        dec_key_gen;
  logic        key_clear;
  logic        data_out_clear;
  ctrl_phase_e phase;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  aes_cmd_latch u_cmd_latch (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .cmd_i            (cmd_i),
    .cmd_done_i       (cmd_done),
    .cmd_valid_o      (cmd_valid),
    .cmd_illegal_o    (cmd_illegal),
    .is_clear_o       (is_clear),
    .op_o             (op),
    .key_len_o        (key_len),
    .dec_key_gen_o    (dec_key_gen),
    .key_clear_o      (key_clear),
    .data_out_clear_o (data_out_clear)
  );

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  aes_round_fsm u_round_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cmd_valid_i          (cmd_valid),
    .cmd_illegal_i        (cmd_illegal),
    .is_clear_i           (is_clear),
    .key_len_i            (key_len),
    .dec_key_gen_i        (dec_key_gen),
    .key_clear_i          (key_clear),
    .data_out_clear_i     (data_out_clear),
    .cmd_done_o           (cmd_done),
    .phase_o              (phase),
    .state_we_o           (state_we_o),
    .sub_bytes_en_o       (sub_bytes_en_o),
    .sub_bytes_out_req_i  (sub_bytes_out_req_i),
    .sub_bytes_out_ack_o  (sub_bytes_out_ack_o),
    .key_expand_en_o      (key_expand_en_o),
    .key_expand_out_req_i (key_expand_out_req_i),
    .key_expand_out_ack_o (key_expand_out_ack_o),
    .key_expand_clear_o   (key_expand_clear_o),
    .key_full_we_o        (key_full_we_o),
    .key_dec_we_o         (key_dec_we_o),
    .rnd_ctr_o            (rnd_ctr_o),
    .out_valid_o          (out_valid_o),
    .out_ready_i          (out_ready_i),
    .sel_err_i            (sel_err_i),
    .ctr_err_i            (ctr_err_i),
    .fatal_i              (fatal_i),
    .alert_o              (alert_o)
  );

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////

  aes_mux_sel u_mux_sel (
    .phase_i          (phase),
    .op_i             (op),
    .key_len_i        (key_len),
    .dec_key_gen_i    (dec_key_gen),
    .key_clear_i      (key_clear),
    .data_out_clear_i (data_out_clear),
    .state_sel_o      (state_sel_o),
    .add_rk_sel_o     (add_rk_sel_o),
    .key_full_sel_o   (key_full_sel_o),
    .key_dec_sel_o    (key_dec_sel_o),
    .key_words_sel_o  (key_words_sel_o),
    .round_key_sel_o  (round_key_sel_o)
  );

endmodule

/* aes_mux_sel.sv */
// AES selector encoder mapping phase, direction and key length to data path mux selects
module aes_mux_sel import aes_ctrl_pkg::*; (
  input  ctrl_phase_e    phase_i,
  input  ciph_op_e       op_i,
  input  key_len_e       key_len_i,
  input  logic           dec_key_gen_i,
  input  logic           key_clear_i,
  input  logic           data_out_clear_i,

  output state_sel_e     state_sel_o,
  output add_rk_sel_e    add_rk_sel_o,
  output key_full_sel_e  key_full_sel_o,
  output key_dec_sel_e   key_dec_sel_o,
  output key_words_sel_e key_words_sel_o,
  output round_key_sel_e round_key_sel_o
);

  key_words_sel_e init_words;
  key_words_sel_e round_words;

  ////////////////////////////////////////
  // Key word tables
  ////////////////////////////////////////

  // Initial round, inverse starts from the top of the expanded key
  always_comb begin
    case (key_len_i)
      AES_192: init_words = (op_i == CIPH_INV) ? KEY_WORDS_2345 : KEY_WORDS_0123;
      AES_256: init_words = (op_i == CIPH_INV) ? KEY_WORDS_4567 : KEY_WORDS_0123;
      default: init_words = KEY_WORDS_0123;
    endcase
  end

  // Regular and final rounds
  always_comb begin
    case (key_len_i)
      AES_192: round_words = (op_i == CIPH_INV) ? KEY_WORDS_0123 : KEY_WORDS_2345;
      AES_256: round_words = (op_i == CIPH_INV) ? KEY_WORDS_0123 : KEY_WORDS_4567;
      default: round_words = KEY_WORDS_0123;
    endcase
  end

  ////////////////////////////////////////
  // Selector encoding
  ////////////////////////////////////////

  always_comb begin
    state_sel_o     = STATE_ROUND;
    add_rk_sel_o    = ADD_RK_ROUND;
    key_full_sel_o  = KEY_FULL_ROUND;
    key_dec_sel_o   = KEY_DEC_EXPAND;
    key_words_sel_o = KEY_WORDS_ZERO;
    round_key_sel_o = ROUND_KEY_DIRECT;

    unique case (phase_i)
      CTRL_IDLE: begin
        // Key generation loads no data into the state
        state_sel_o    = dec_key_gen_i ? STATE_CLEAR : STATE_INIT;
        key_full_sel_o = (op_i == CIPH_INV && !dec_key_gen_i) ? KEY_FULL_DEC_INIT
                                                               : KEY_FULL_ENC_INIT;
      end
      CTRL_INIT: begin
        add_rk_sel_o    = ADD_RK_INIT;
        key_words_sel_o = dec_key_gen_i ? KEY_WORDS_ZERO : init_words;
      end
      CTRL_ROUND: begin
        key_words_sel_o = dec_key_gen_i ? KEY_WORDS_ZERO : round_words;
        // Equivalent inverse cipher mixes the round key
        round_key_sel_o = (op_i == CIPH_INV) ? ROUND_KEY_MIXED : ROUND_KEY_DIRECT;
      end
      CTRL_FINISH: begin
        // No MixColumns in the last round
        add_rk_sel_o    = ADD_RK_FINAL;
        key_words_sel_o = dec_key_gen_i ? KEY_WORDS_ZERO : round_words;
        state_sel_o     = STATE_CLEAR;
      end
      CTRL_CLEAR_S: state_sel_o = STATE_CLEAR;
      CTRL_CLEAR_KD: begin
        if (key_clear_i) begin
          key_full_sel_o = KEY_FULL_CLEAR;
          key_dec_sel_o  = KEY_DEC_CLEAR;
        end
        // Pass the wiped state through to the output registers
        if (data_out_clear_i) begin
          add_rk_sel_o = ADD_RK_INIT;
        end
      end
      default: begin
        state_sel_o = STATE_ROUND;
      end
    endcase
  end

endmodule

/* aes_round_fsm.sv */
// AES round FSM pacing SubBytes and KeyExpand and driving the data path write enables
module aes_round_fsm import aes_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Latched command
  input  logic                 cmd_valid_i,
  input  logic                 cmd_illegal_i,
  input  logic                 is_clear_i,
  input  key_len_e             key_len_i,
  input  logic                 dec_key_gen_i,
  input  logic                 key_clear_i,
  input  logic                 data_out_clear_i,
  output logic                 cmd_done_o,
  output ctrl_phase_e          phase_o,

  // Cipher data path
  output logic                 state_we_o,
  output logic                 sub_bytes_en_o,
  input  logic                 sub_bytes_out_req_i,
  output logic                 sub_bytes_out_ack_o,

  // Key expand data path
  output logic                 key_expand_en_o,
  input  logic                 key_expand_out_req_i,
  output logic                 key_expand_out_ack_o,
  output logic                 key_expand_clear_o,
  output logic                 key_full_we_o,
  output logic                 key_dec_we_o,
  output logic [RND_CTR_W-1:0] rnd_ctr_o,

  // Result handshake
  output logic                 out_valid_o,
  input  logic                 out_ready_i,

  // Faults
  input  logic                 sel_err_i,
  input  logic                 ctr_err_i,
  input  logic                 fatal_i,
  output logic                 alert_o
);

  ctrl_phase_e          phase_d, phase_q;
  logic [RND_CTR_W-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [RND_CTR_W-1:0] num_rounds_d, num_rounds_q;
  logic [RND_CTR_W-1:0] last_regular;
  logic                 advance;

  // Rounds before the final one
  assign last_regular = num_rounds_q - RND_CTR_W'(1);

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin
    phase_d              = phase_q;
    rnd_ctr_d            = rnd_ctr_q;
    num_rounds_d         = num_rounds_q;
    advance              = 1'b0;
    cmd_done_o           = 1'b0;
    state_we_o           = 1'b0;
    sub_bytes_en_o       = 1'b0;
    sub_bytes_out_ack_o  = 1'b0;
    key_expand_en_o      = 1'b0;
    key_expand_out_ack_o = 1'b0;
    key_expand_clear_o   = 1'b0;
    key_full_we_o        = 1'b0;
    key_dec_we_o         = 1'b0;
    out_valid_o          = 1'b0;
    alert_o              = 1'b0;

    unique case (phase_q)
      CTRL_IDLE: begin
        if (cmd_valid_i && !cmd_illegal_i) begin
          if (is_clear_i) begin
            // Data clear wipes the state first
            phase_d = data_out_clear_i ? CTRL_CLEAR_S : CTRL_CLEAR_KD;
          end else begin
            // Load state and full key, reset key expansion
            state_we_o         = 1'b1;
            key_full_we_o      = 1'b1;
            key_expand_clear_o = 1'b1;
            case (key_len_i)
              AES_192: num_rounds_d = NUM_ROUNDS_192;
              AES_256: num_rounds_d = NUM_ROUNDS_256;
              default: num_rounds_d = NUM_ROUNDS_128;
            endcase
            rnd_ctr_d = '0;
            phase_d   = CTRL_INIT;
          end
        end
      end

      CTRL_INIT: begin
        // AES-256 has its first two round keys at hand
        if (key_len_i != AES_256) begin
          key_expand_en_o = 1'b1;
          advance         = key_expand_out_req_i;
        end else begin
          advance = 1'b1;
        end
        if (advance) begin
          key_expand_out_ack_o = key_len_i != AES_256;
          key_full_we_o        = key_len_i != AES_256;
          state_we_o           = ~dec_key_gen_i;
          rnd_ctr_d            = rnd_ctr_q + RND_CTR_W'(1);
          phase_d              = CTRL_ROUND;
        end
      end

      CTRL_ROUND: begin
        // Key generation runs KeyExpand alone
        sub_bytes_en_o  = ~dec_key_gen_i;
        key_expand_en_o = 1'b1;
        advance = key_expand_out_req_i & (dec_key_gen_i | sub_bytes_out_req_i);
        if (advance) begin
          sub_bytes_out_ack_o  = ~dec_key_gen_i;
          key_expand_out_ack_o = 1'b1;
          state_we_o           = ~dec_key_gen_i;
          key_full_we_o        = 1'b1;
          rnd_ctr_d            = rnd_ctr_q + RND_CTR_W'(1);
          if (rnd_ctr_q >= last_regular) begin
            phase_d = CTRL_FINISH;
            if (dec_key_gen_i) begin
              // Decryption key is ready, try to hand it off right away
              key_dec_we_o = 1'b1;
              out_valid_o  = ~sel_err_i;
              if (out_valid_o && out_ready_i) begin
                cmd_done_o = 1'b1;
                phase_d    = CTRL_IDLE;
              end
            end
          end
        end
      end

      CTRL_FINISH: begin
        // Final round waits for SubBytes, then for the result handshake
        sub_bytes_en_o = ~dec_key_gen_i;
        advance        = sub_bytes_out_req_i | dec_key_gen_i;
        out_valid_o    = advance & ~sel_err_i;
        if (out_valid_o && out_ready_i) begin
          sub_bytes_out_ack_o = ~dec_key_gen_i;
          // State is wiped on the way out
          state_we_o = 1'b1;
          cmd_done_o = 1'b1;
          phase_d    = CTRL_IDLE;
        end
      end

      CTRL_CLEAR_S: begin
        state_we_o = 1'b1;
        phase_d    = CTRL_CLEAR_KD;
      end

      CTRL_CLEAR_KD: begin
        key_full_we_o = key_clear_i;
        key_dec_we_o  = key_clear_i;
        out_valid_o   = ~sel_err_i;
        if (out_valid_o && out_ready_i) begin
          cmd_done_o = 1'b1;
          phase_d    = CTRL_IDLE;
        end
      end

      // Terminal, left only by reset
      CTRL_ERROR: alert_o = 1'b1;

      default: begin
        alert_o = 1'b1;
        phase_d = CTRL_ERROR;
      end
    endcase

    // Any fault wins over the regular flow and keeps the command held
    if (sel_err_i || ctr_err_i || fatal_i || (cmd_valid_i && cmd_illegal_i)) begin
      phase_d    = CTRL_ERROR;
      cmd_done_o = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q      <= CTRL_IDLE;
      rnd_ctr_q    <= '0;
      num_rounds_q <= '0;
    end else begin
      phase_q      <= phase_d;
      rnd_ctr_q    <= rnd_ctr_d;
      num_rounds_q <= num_rounds_d;
    end
  end

  assign phase_o   = phase_q;
  assign rnd_ctr_o = rnd_ctr_q;

endmodule

/* sources.f */
aes_ctrl_pkg.sv
aes_cmd_latch.sv
aes_round_fsm.sv
aes_mux_sel.sv
aes_ctrl_top.sv
tb_clk_gen.sv
tb_aes_ctrl_assert.sv
tb_aes_ctrl.sv

/* tb_aes_ctrl.sv */
// Testbench for the AES control top with a data path model and pattern driven checks
module tb_aes_ctrl import aes_ctrl_pkg::*; ();

  localparam int NUM_PAT   = 15;
  localparam int NUM_FIELD = 10;

  logic clk_i, gen_rst_n, tb_rst_n, rst_n;
  logic in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  aes_cmd_u cmd_i;
  logic sub_bytes_out_req_i, key_expand_out_req_i, sel_err_i, ctr_err_i, fatal_i;
  logic state_we_o, sub_bytes_en_o, sub_bytes_out_ack_o, key_full_we_o, key_dec_we_o;
  logic key_expand_en_o, key_expand_out_ack_o, key_expand_clear_o, alert_o;
  logic [RND_CTR_W-1:0] rnd_ctr_o;
  state_sel_e     state_sel_o;
  add_rk_sel_e    add_rk_sel_o;
  key_full_sel_e  key_full_sel_o;
  key_dec_sel_e   key_dec_sel_o;
  key_words_sel_e key_words_sel_o;
  round_key_sel_e round_key_sel_o;

  logic [7:0] pat_mem [0:NUM_PAT*NUM_FIELD-1];
  integer seed = 32'h7e00;
  int errors = 0;
  int failed_tests = 0;
  // Per test monitor state set up by the main process
  int ke_ack_cnt, sb_ack_cnt, kdw_cnt, sb_en_cnt, sb_lat, ke_lat, nr_cur;
  logic sel_on, clr_on, st_clr_seen, inv_cur;
  logic [1:0] kl_cur;
  logic sb_ack_q, ke_ack_q, sb_en_q, ke_en_q;
  int sb_wait, ke_wait;

  assign rst_n = gen_rst_n & tb_rst_n;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_n_o(gen_rst_n));

  aes_ctrl_top u_dut (
    .clk_i, .rst_ni(rst_n), .in_valid_i, .in_ready_o, .cmd_i, .out_valid_o, .out_ready_i,
    .state_sel_o, .state_we_o, .add_rk_sel_o, .sub_bytes_en_o, .sub_bytes_out_req_i,
    .sub_bytes_out_ack_o, .key_full_sel_o, .key_full_we_o, .key_dec_sel_o, .key_dec_we_o,
    .key_expand_en_o, .key_expand_out_req_i, .key_expand_out_ack_o, .key_expand_clear_o,
    .rnd_ctr_o, .key_words_sel_o, .round_key_sel_o, .sel_err_i, .ctr_err_i, .fatal_i, .alert_o
  );

  task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  function automatic int pick_lat(input int lat);
    // Zero in the table asks for a random latency of 0 to 3
    if (lat == 0) return $random(seed) & 3;
    return lat;
  endfunction

  // Key word tables for the initial and the later rounds
  function automatic logic [1:0] exp_words(input logic [1:0] kl, input logic inv,
                                           input logic init);
    if (kl == 2'b00) return KEY_WORDS_0123;
    if (init) return inv ? ((kl == 2'b01) ? KEY_WORDS_2345 : KEY_WORDS_4567) : KEY_WORDS_0123;
    return inv ? KEY_WORDS_0123 : ((kl == 2'b01) ? KEY_WORDS_2345 : KEY_WORDS_4567);
  endfunction

  ////////////////////////////////////////
  // Monitor sampled on the rising edge
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    sb_ack_q = sub_bytes_out_ack_o;
    ke_ack_q = key_expand_out_ack_o;
    sb_en_q  = sub_bytes_en_o;
    ke_en_q  = key_expand_en_o;
    if (rst_n) begin
      if (key_expand_out_ack_o) ke_ack_cnt++;
      if (sub_bytes_out_ack_o) sb_ack_cnt++;
      if (key_dec_we_o) kdw_cnt++;
      if (sub_bytes_en_o) sb_en_cnt++;
      if (state_we_o && state_sel_o == STATE_CLEAR && !out_valid_o) st_clr_seen = 1'b1;
      if (clr_on && key_dec_we_o) begin
        // Key clear writes both key registers together
        check_val("key_full_we_o", 32'(key_full_we_o), 1);
        check_val("key_full_sel_o", 32'(key_full_sel_o), 32'(KEY_FULL_CLEAR));
        check_val("key_dec_sel_o", 32'(key_dec_sel_o), 32'(KEY_DEC_CLEAR));
      end
      // Skip the IDLE cycle that loads the command
      if (sel_on && !key_expand_clear_o) begin
        if (rnd_ctr_o == 0) begin
          check_val("add_rk_sel_o", 32'(add_rk_sel_o), 32'(ADD_RK_INIT));
          check_val("key_words_sel_o", 32'(key_words_sel_o), 32'(exp_words(kl_cur, inv_cur, 1)));
          check_val("round_key_sel_o", 32'(round_key_sel_o), 32'(ROUND_KEY_DIRECT));
        end else begin
          // Last round adds its key without MixColumns
          check_val("add_rk_sel_o", 32'(add_rk_sel_o),
                    (int'(rnd_ctr_o) < nr_cur) ? 32'(ADD_RK_ROUND) : 32'(ADD_RK_FINAL));
          check_val("key_words_sel_o", 32'(key_words_sel_o), 32'(exp_words(kl_cur, inv_cur, 0)));
          // Final round takes the key as is
          check_val("round_key_sel_o", 32'(round_key_sel_o),
                    (int'(rnd_ctr_o) < nr_cur && inv_cur) ? 32'(ROUND_KEY_MIXED)
                                                          : 32'(ROUND_KEY_DIRECT));
        end
      end
    end
  end

  ////////////////////////////////////////
  // Data path model driven on the falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_n) begin
      sub_bytes_out_req_i  = 1'b0;
      key_expand_out_req_i = 1'b0;
      sb_wait = -1;
      ke_wait = -1;
    end else begin
      if (sb_ack_q) begin
        sub_bytes_out_req_i = 1'b0;
        sb_wait = -1;
      end else if (sb_en_q && !sub_bytes_out_req_i) begin
        if (sb_wait < 0) sb_wait = pick_lat(sb_lat);
        if (sb_wait == 0) sub_bytes_out_req_i = 1'b1;
        else sb_wait--;
      end
      if (ke_ack_q) begin
        key_expand_out_req_i = 1'b0;
        ke_wait = -1;
      end else if (ke_en_q && !key_expand_out_req_i) begin
        if (ke_wait < 0) ke_wait = pick_lat(ke_lat);
        if (ke_wait == 0) key_expand_out_req_i = 1'b1;
        else ke_wait--;
      end
    end
  end

  ////////////////////////////////////////
  // One pattern from command to result
  ////////////////////////////////////////

  task automatic run_pattern(input int idx);
    int base, hold, stall, err0;
    logic [7:0] cmd, exp_rnd, exp_ke, exp_sb, exp_kdw;
    logic fault, fired, done, waiting, exp_alert, is_start, dkg;
    logic ov, rd, al, ir;
    logic [RND_CTR_W-1:0] rc, acc_rnd;
    base      = idx * NUM_FIELD;
    cmd       = pat_mem[base];
    hold      = int'(pat_mem[base+3]);
    fault     = pat_mem[base+4][0];
    exp_rnd   = pat_mem[base+5];
    exp_ke    = pat_mem[base+6];
    exp_sb    = pat_mem[base+7];
    exp_kdw   = pat_mem[base+8];
    exp_alert = pat_mem[base+9][0];
    is_start  = cmd[7:6] == CMD_KIND_START;
    dkg       = cmd[2];
    err0      = errors;
    fired     = 1'b0;
    done      = 1'b0;
    waiting   = 1'b0;
    stall     = 0;
    acc_rnd   = '0;
    @(negedge clk_i);
    ke_ack_cnt  = 0;
    sb_ack_cnt  = 0;
    kdw_cnt     = 0;
    sb_en_cnt   = 0;
    st_clr_seen = 1'b0;
    sb_lat      = int'(pat_mem[base+1]);
    ke_lat      = int'(pat_mem[base+2]);
    kl_cur      = cmd[4:3];
    inv_cur     = cmd[5];
    nr_cur      = (kl_cur == 2'b01) ? 12 : ((kl_cur == 2'b10) ? 14 : 10);
    out_ready_i = hold == 0;
    in_valid_i  = 1'b1;
    cmd_i       = cmd;
    do @(posedge clk_i); while (!in_ready_o);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    cmd_i      = '0;
    sel_on     = is_start && !dkg && !exp_alert;
    clr_on     = cmd[7:6] == CMD_KIND_CLEAR && cmd[5];
    while (!done) begin
      @(posedge clk_i);
      ov = out_valid_o;
      rd = out_ready_i;
      al = alert_o;
      ir = in_ready_o;
      rc = rnd_ctr_o;
      // Back-pressure keeps the result offered and the input closed
      if (waiting) check_val("out_valid_o", 32'(ov), 1);
      if (ov && !rd) begin
        check_val("in_ready_o", 32'(ir), 0);
        stall++;
      end
      waiting = ov && !rd;
      if (ov && rd) begin
        acc_rnd = rc;
        done = 1'b1;
      end
      if (al) done = 1'b1;
      @(negedge clk_i);
      fatal_i = 1'b0;
      if (fault && !fired && rc >= 2) begin
        fatal_i = 1'b1;
        fired   = 1'b1;
      end
      out_ready_i = stall >= hold;
    end
    sel_on = 1'b0;
    clr_on = 1'b0;
    if (exp_alert) begin
      repeat (4) begin
        @(posedge clk_i);
        check_val("alert_o", 32'(alert_o), 1);
        check_val("in_ready_o", 32'(in_ready_o), 0);
      end
      // Only a reset leaves the error state
      @(negedge clk_i);
      tb_rst_n = 1'b0;
      fatal_i  = 1'b0;
      repeat (3) @(negedge clk_i);
      tb_rst_n = 1'b1;
      @(posedge clk_i);
      check_val("in_ready_o", 32'(in_ready_o), 1);
      check_val("alert_o", 32'(alert_o), 0);
      check_val("rnd_ctr_o", 32'(rnd_ctr_o), 0);
    end else begin
      check_val("alert_o", 32'(alert_o), 0);
      if (exp_rnd != 8'hff) check_val("rnd_ctr_o", 32'(acc_rnd), 32'(exp_rnd));
      check_val("key_expand_out_ack_o count", ke_ack_cnt, 32'(exp_ke));
      check_val("sub_bytes_out_ack_o count", sb_ack_cnt, 32'(exp_sb));
      check_val("key_dec_we_o count", kdw_cnt, 32'(exp_kdw));
      if (is_start && dkg) check_val("sub_bytes_en_o count", sb_en_cnt, 0);
      if (!is_start) check_val("state clear before out_valid_o", 32'(st_clr_seen), 32'(cmd[4]));
    end
    if (errors != err0) failed_tests++;
    $display("Test %0d cmd %02h %s", idx, cmd, (errors == err0) ? "passed" : "failed");
  endtask

  // Watchdog sized from the pattern count
  initial begin
    repeat (NUM_PAT * 200 + 100) @(posedge clk_i);
    $display("Timeout: the run did not finish in time");
    $display("Errors found");
    $finish;
  end

  initial begin
    in_valid_i           = 1'b0;
    cmd_i                = '0;
    out_ready_i          = 1'b0;
    sub_bytes_out_req_i  = 1'b0;
    key_expand_out_req_i = 1'b0;
    sel_err_i            = 1'b0;
    ctr_err_i            = 1'b0;
    fatal_i              = 1'b0;
    tb_rst_n             = 1'b1;
    sel_on               = 1'b0;
    clr_on               = 1'b0;
    $readmemh("aes_ctrl_patterns.txt", pat_mem);
    @(posedge rst_n);
    // Reset values
    @(posedge clk_i);
    check_val("in_ready_o", 32'(in_ready_o), 1);
    check_val("out_valid_o", 32'(out_valid_o), 0);
    check_val("alert_o", 32'(alert_o), 0);
    check_val("rnd_ctr_o", 32'(rnd_ctr_o), 0);
    for (int i = 0; i < NUM_PAT; i++) run_pattern(i);
    $display("Tests %0d, failed %0d, errors %0d", NUM_PAT, failed_tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* tb_aes_ctrl_assert.sv */
// Concurrent checks on the AES round FSM handshakes and alert
module tb_aes_ctrl_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic sub_bytes_out_req_i,
  input logic sub_bytes_out_ack_o,
  input logic key_expand_out_req_i,
  input logic key_expand_out_ack_o,
  input logic out_valid_o,
  input logic out_ready_i,
  input logic sel_err_i,
  input logic ctr_err_i,
  input logic fatal_i,
  input logic alert_o
);

  // Acknowledge only while the unit requests
  sb_ack_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sub_bytes_out_ack_o |-> sub_bytes_out_req_i)
    else $error("SubBytes acknowledge without request");

  ke_ack_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    key_expand_out_ack_o |-> key_expand_out_req_i)
    else $error("KeyExpand acknowledge without request");

  // Alert is sticky until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o)
    else $error("Alert dropped without reset");

  // Result stays offered until taken
  out_valid_hold: assert property (@(posedge clk_i)
    disable iff (!rst_ni || sel_err_i || ctr_err_i || fatal_i)
    out_valid_o && !out_ready_i |=> out_valid_o)
    else $error("Result valid dropped before it was taken");

endmodule

bind aes_round_fsm tb_aes_ctrl_assert u_assert (
  .clk_i                (clk_i),
  .rst_ni               (rst_ni),
  .sub_bytes_out_req_i  (sub_bytes_out_req_i),
  .sub_bytes_out_ack_o  (sub_bytes_out_ack_o),
  .key_expand_out_req_i (key_expand_out_req_i),
  .key_expand_out_ack_o (key_expand_out_ack_o),
  .out_valid_o          (out_valid_o),
  .out_ready_i          (out_ready_i),
  .sel_err_i            (sel_err_i),
  .ctr_err_i            (ctr_err_i),
  .fatal_i              (fatal_i),
  .alert_o              (alert_o)
);

/* tb_clk_gen.sv */
// Testbench clock and power-on reset generator
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Period of 8, reset released on a falling edge after 8 cycles
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule
